/* sim.f */
+incdir+test
source/video_pkg.sv
source/cen_divider.sv
source/raster_timer.sv
source/slot_timer.sv
source/scroll_ram_port.sv
source/video_top.sv
test/video_assert.sv
test/tb_video_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_video_top -o tb_video_top \
    && out="$(./obj_dir/tb_video_top)" \
    ; echo "$out" \
    ; echo "$out" | grep -q "Test completed successfully" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

/* test/tb_video_tasks.svh */
`ifndef TB_VIDEO_TASKS_SVH
`define TB_VIDEO_TASKS_SVH

//////////////////////////////
// Reference rules
//////////////////////////////

function automatic logic [3:0] ref_pattern(input logic [2:0] ph);
    case (ph)
        3'd0:    return 4'b0110;
        3'd1:    return 4'b1001;
        3'd2:    return 4'b0111;
        3'd3:    return 4'b1010;
        3'd4:    return 4'b0101;
        default: return 4'b1011;
    endcase
endfunction

// Mixes all eleven address bits
function automatic video_pkg::byte_t fill_byte(input video_pkg::scroll_addr_t a);
    return a[7:0] ^ {a[10:8], a[10:8], a[9:8]};
endfunction

function automatic video_pkg::scroll_addr_t gfx_addr(input video_pkg::hcount_t h,
                                                     input video_pkg::vcount_t v,
                                                     input logic hb_n);
    if (!hb_n)
        return {1'b0, h[2:1], v[7:0]};          // Hscroll entry
    return {4'b1111, h[2], h[8:3]};             // Vscroll entry
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic compare_word(input string name, input video_pkg::cpu_word_t act,
                            input video_pkg::cpu_word_t exp);
    check_count++;
    if (act !== exp)
    begin
        error_count++;
        $display("MISMATCH %0t ns: %s got %h expected %h", $time, name, act, exp);
    end
endtask

task automatic compare_byte(input string name, input video_pkg::byte_t act,
                            input video_pkg::byte_t exp);
    check_count++;
    if (act !== exp)
    begin
        error_count++;
        $display("MISMATCH %0t ns: %s got %h expected %h", $time, name, act, exp);
    end
endtask

task automatic compare_count(input string name, input video_pkg::hcount_t act,
                             input video_pkg::hcount_t exp);
    check_count++;
    if (act !== exp)
    begin
        error_count++;
        $display("MISMATCH %0t ns: %s got %0d expected %0d", $time, name, act, exp);
    end
endtask

task automatic compare_bit(input string name, input logic act, input logic exp);
    check_count++;
    if (act !== exp)
    begin
        error_count++;
        $display("MISMATCH %0t ns: %s got %b expected %b", $time, name, act, exp);
    end
endtask

//////////////////////////////
// Bus and timing helpers
//////////////////////////////

task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n  = 1'b0;
    vzcs_n = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    rst_n  = 1'b1;
endtask

// Returns at the negedge before a 6M positive enable edge
task automatic wait_pixel(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < 4 * PIX_CLKS)
    begin
        @(negedge clk);
        ok = !o_clk6mpcen_n;
        n++;
    end
    if (!ok)
    begin
        error_count++;
        $display("No 6M positive enable seen within %0d cycles", 4 * PIX_CLKS);
    end
endtask

task automatic cpu_write(input video_pkg::cpu_addr_t a, input video_pkg::cpu_word_t d);
    @(posedge clk);
    #2;
    cpu_addr  = a;
    cpu_dout  = d;
    cpu_rw    = 1'b0;
    cpu_lds_n = 1'b0;
    vzcs_n    = 1'b0;
    repeat (32) @(posedge clk);
    #2;
    vzcs_n    = 1'b1;
    cpu_rw    = 1'b1;
    cpu_lds_n = 1'b1;
    mem_model[a[10:0]] = d[7:0];
endtask

task automatic cpu_read(input video_pkg::cpu_addr_t a, output video_pkg::cpu_word_t d);
    @(posedge clk);
    #2;
    cpu_addr  = a;
    cpu_rw    = 1'b1;
    cpu_lds_n = 1'b0;
    vzcs_n    = 1'b0;
    repeat (31) @(posedge clk);
    @(negedge clk);
    d = o_cpu_din;                              // Sampled while still selected
    @(posedge clk);
    #2;
    vzcs_n    = 1'b1;
    cpu_lds_n = 1'b1;
endtask

task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before)
        $display("%s: ok", name);
    else
    begin
        failed_tests++;
        $display("%s: %0d errors", name, error_count - errs_before);
    end
endtask

//////////////////////////////
// Tests
//////////////////////////////

task automatic test_cen_pattern();
    int e0;
    e0 = error_count;
    apply_reset();
    @(negedge clk);
    compare_bit("o_clk9mpcen_n", o_clk9mpcen_n, 1'b1);
    compare_bit("o_clk9mncen_n", o_clk9mncen_n, 1'b1);
    compare_bit("o_clk6mpcen_n", o_clk6mpcen_n, 1'b1);
    compare_bit("o_clk6mncen_n", o_clk6mncen_n, 1'b1);
    repeat (120)
    begin
        @(negedge clk);
        compare_bit("o_clk9mpcen_n", o_clk9mpcen_n, m_pat[3] | cen18_n);
        compare_bit("o_clk9mncen_n", o_clk9mncen_n, m_pat[2] | cen18_n);
        compare_bit("o_clk6mpcen_n", o_clk6mpcen_n, m_pat[1] | cen18_n);
        compare_bit("o_clk6mncen_n", o_clk6mncen_n, m_pat[0] | cen18_n);
        compare_bit("o_time2_n", o_time2_n, !(m_h1 && m_slot[2]));
        compare_bit("o_champx", o_champx, m_slot[2] || m_slot[1]);
    end
    report_test("test_cen_pattern", e0);
endtask

task automatic test_raster_count();
    int                 e0;
    int                 n;
    logic               ok;
    video_pkg::hcount_t exp_h;
    video_pkg::vcount_t exp_v;
    e0 = error_count;
    apply_reset();
    @(negedge clk);
    exp_h = H_FIRST;
    exp_v = V_FIRST;
    compare_count("o_hcount", o_hcount, exp_h);
    n  = 0;
    ok = 1'b1;
    while (ok && n < 400)                       // Passes one line wrap
    begin
        wait_pixel(ok);
        @(negedge clk);
        if (exp_h == H_LAST)
        begin
            exp_h = H_FIRST;
            exp_v = (exp_v == V_LAST) ? V_FIRST : exp_v + 9'd1;
        end
        else
            exp_h = exp_h + 9'd1;
        compare_count("o_hcount", o_hcount, exp_h);
        compare_count("o_vcount", o_vcount, exp_v);
        n++;
    end
    report_test("test_raster_count", e0);
endtask

task automatic test_blank_sync();
    int   e0;
    int   n;
    logic ok;
    logic hact;
    logic vact;
    e0 = error_count;
    apply_reset();
    n  = 0;
    ok = 1'b1;
    while (ok && n < 10 * 384)                  // Lines 248 to 257, across vsync end
    begin
        wait_pixel(ok);
        @(negedge clk);
        hact = (o_hcount >= H_ACT_FIRST) && (o_hcount <= H_ACT_LAST);
        vact = (o_vcount >= V_ACT_FIRST) && (o_vcount <= V_ACT_LAST);
        compare_bit("o_hblank_n", o_hblank_n, hact);
        compare_bit("o_vblank_n", o_vblank_n, vact);
        compare_bit("o_vsync_n", o_vsync_n,
                    !((o_vcount >= VSYNC_FIRST) && (o_vcount <= VSYNC_LAST)));
        compare_bit("o_blk", o_blk, hact && vact);
        n++;
    end
    report_test("test_blank_sync", e0);
endtask

task automatic test_cpu_access();
    int                   e0;
    video_pkg::cpu_addr_t addrs [0:31];
    video_pkg::cpu_word_t d;
    e0 = error_count;
    apply_reset();
    for (int i = 0; i < 32; i++)
    begin
        addrs[i] = video_pkg::cpu_addr_t'($random(seed));
        cpu_write(addrs[i], video_pkg::cpu_word_t'($random(seed)));
    end
    for (int i = 0; i < 32; i++)
    begin
        cpu_read(addrs[i], d);
        compare_word("o_cpu_din", d, {8'hFF, mem_model[addrs[i][10:0]]});
    end
    @(negedge clk);
    compare_word("o_cpu_din", o_cpu_din, 16'hFFFF);  // Deselected
    report_test("test_cpu_access", e0);
endtask

task automatic test_gfx_fetch();
    int                 e0;
    int                 n;
    logic               ok;
    logic               hb_n;
    video_pkg::hcount_t h;
    video_pkg::vcount_t v;
    e0 = error_count;
    for (int a = 0; a < 2048; a++)
        cpu_write(video_pkg::cpu_addr_t'(a), {8'h00, fill_byte(video_pkg::scroll_addr_t'(a))});
    n  = 0;
    ok = 1'b1;
    while (ok && n < 600)
    begin
        wait_pixel(ok);
        h    = o_hcount;                        // Pixel that ends at this edge
        v    = o_vcount;
        hb_n = o_hblank_n;
        @(negedge clk);
        if (h[0])
        begin
            compare_byte("o_scroll_val", o_scroll_val, mem_model[gfx_addr(h, v, hb_n)]);
            n++;
        end
    end
    report_test("test_gfx_fetch", e0);
endtask

`endif

/* test/tb_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

    //////////////////////////////
    // Raster ranges, same as DUT
    //////////////////////////////

    localparam video_pkg::hcount_t H_FIRST     = 9'd128;
    localparam video_pkg::hcount_t H_LAST      = 9'd511;
    localparam video_pkg::vcount_t V_FIRST     = 9'd248;
    localparam video_pkg::vcount_t V_LAST      = 9'd511;
    localparam video_pkg::hcount_t H_ACT_FIRST = 9'd160;
    localparam video_pkg::hcount_t H_ACT_LAST  = 9'd415;
    localparam video_pkg::vcount_t V_ACT_FIRST = 9'd272;
    localparam video_pkg::vcount_t V_ACT_LAST  = 9'd495;
    localparam video_pkg::vcount_t VSYNC_FIRST = 9'd248;
    localparam video_pkg::vcount_t VSYNC_LAST  = 9'd255;

    localparam int CLK_NS    = 40;
    localparam int PIX_CLKS  = 6;       // Three 18M enables per pixel
    localparam int ACC_CLKS  = 34;      // One CPU access with handover

    // Test lengths in MCLK cycles
    localparam int LEN_CEN    = 200;
    localparam int LEN_COUNT  = 400 * PIX_CLKS + 100;
    localparam int LEN_BLANK  = 10 * 384 * PIX_CLKS + 100;
    localparam int LEN_CPU    = 65 * ACC_CLKS + 100;
    localparam int LEN_GFX    = 2048 * ACC_CLKS + 1200 * PIX_CLKS + 100;
    localparam int TOTAL_CLKS = LEN_CEN + LEN_COUNT + LEN_BLANK + LEN_CPU + LEN_GFX;

    logic                 clk;
    logic                 rst_n;
    logic                 cen18_n;
    video_pkg::cpu_addr_t cpu_addr;
    video_pkg::cpu_word_t cpu_dout;
    logic                 cpu_rw;
    logic                 cpu_lds_n;
    logic                 vzcs_n;

    wire                  o_clk9mpcen_n;
    wire                  o_clk9mncen_n;
    wire                  o_clk6mpcen_n;
    wire                  o_clk6mncen_n;
    video_pkg::hcount_t   o_hcount;
    video_pkg::vcount_t   o_vcount;
    wire                  o_hblank_n;
    wire                  o_vblank_n;
    wire                  o_vsync_n;
    wire                  o_blk;
    wire                  o_time2_n;
    wire                  o_champx;
    video_pkg::cpu_word_t o_cpu_din;
    video_pkg::byte_t     o_scroll_val;

    integer               seed;
    int                   error_count;
    int                   check_count;
    int                   failed_tests;
    video_pkg::byte_t     mem_model [0:2047];   // Scoreboard of CPU writes

    // Divider reference model
    logic [2:0]           m_phase;
    logic [3:0]           m_pat;                // 9MP 9MN 6MP 6MN, low active

    // Slot strobe reference model
    logic                 m_h1;                 // 1H one pixel late
    logic [3:1]           m_slot;               // Top stage loaded first

    `include "tb_video_tasks.svh"

    //////////////////////////////
    // Clock, 18M enable, watchdog
    //////////////////////////////

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk)
    begin
        #2;
        cen18_n = ~cen18_n;                     // Low every other MCLK
    end

    initial
    begin
        #(TOTAL_CLKS * CLK_NS * 3 / 2);
        $display("Watchdog expired before the test sequence ended");
        $display("Test failed");
        $finish;
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_phase <= 3'd5;
            m_pat   <= 4'b1111;
        end
        else if (!cen18_n)
        begin
            m_phase <= (m_phase == 3'd5) ? 3'd0 : m_phase + 3'd1;
            m_pat   <= ref_pattern(m_phase);   // Pattern of the phase left
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_h1   <= 1'b0;
            m_slot <= '0;
        end
        else
        begin
            if (!(m_pat[1] | cen18_n))
                m_h1 <= o_hcount[0];            // On the modelled 6M positive enable
            if (!cen18_n)
                m_slot <= {m_h1, m_slot[3:2]};
        end
    end

    video_top
    #(
        .H_FIRST     (H_FIRST),
        .H_LAST      (H_LAST),
        .V_FIRST     (V_FIRST),
        .V_LAST      (V_LAST),
        .H_ACT_FIRST (H_ACT_FIRST),
        .H_ACT_LAST  (H_ACT_LAST),
        .V_ACT_FIRST (V_ACT_FIRST),
        .V_ACT_LAST  (V_ACT_LAST),
        .VSYNC_FIRST (VSYNC_FIRST),
        .VSYNC_LAST  (VSYNC_LAST)
    )
    u_video_top
    (
        .i_EMU_MCLK         (clk),
        .i_rst_n            (rst_n),
        .i_emu_clk18mncen_n (cen18_n),
        .i_cpu_addr         (cpu_addr),
        .i_cpu_dout         (cpu_dout),
        .i_cpu_rw           (cpu_rw),
        .i_cpu_lds_n        (cpu_lds_n),
        .i_vzcs_n           (vzcs_n),
        .o_clk9mpcen_n      (o_clk9mpcen_n),
        .o_clk9mncen_n      (o_clk9mncen_n),
        .o_clk6mpcen_n      (o_clk6mpcen_n),
        .o_clk6mncen_n      (o_clk6mncen_n),
        .o_hcount           (o_hcount),
        .o_vcount           (o_vcount),
        .o_hblank_n         (o_hblank_n),
        .o_vblank_n         (o_vblank_n),
        .o_vsync_n          (o_vsync_n),
        .o_blk              (o_blk),
        .o_time2_n          (o_time2_n),
        .o_champx           (o_champx),
        .o_cpu_din          (o_cpu_din),
        .o_scroll_val       (o_scroll_val)
    );

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        seed         = 32'h23e2_83a1;
        error_count  = 0;
        check_count  = 0;
        failed_tests = 0;
        rst_n        = 1'b0;
        cen18_n      = 1'b1;
        cpu_addr     = '0;
        cpu_dout     = '0;
        cpu_rw       = 1'b1;
        cpu_lds_n    = 1'b1;
        vzcs_n       = 1'b1;

        test_cen_pattern();
        test_raster_count();
        test_blank_sync();
        test_cpu_access();
        test_gfx_fetch();

        $display("Tests: 5, with errors: %0d, checks: %0d, errors: %0d",
                 failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/video_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module video_assert
(
    input wire i_EMU_MCLK,
    input wire i_rst_n,
    input wire i_emu_clk18mncen_n,
    input wire i_clk9mpcen_n,
    input wire i_clk9mncen_n,
    input wire i_clk6mpcen_n,
    input wire i_clk6mncen_n,
    input wire i_time1,
    input wire i_time2_n
);

    // Enables only inside an 18M enable cycle
    a_cen_gated: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
        i_emu_clk18mncen_n |-> (i_clk9mpcen_n && i_clk9mncen_n &&
                                i_clk6mpcen_n && i_clk6mncen_n))
        else $error("enable active outside an 18M enable");

    a_9m_exclusive: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
        !(!i_clk9mpcen_n && !i_clk9mncen_n))
        else $error("9M positive and negative enables together");

    // Write window sits inside the TIME1 period of the CPU pixel
    a_time_window: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
        !i_time2_n |-> i_time1)
        else $error("TIME2 active outside TIME1");

endmodule

bind cen_divider video_assert u_cen_assert
(
    .i_EMU_MCLK         (i_EMU_MCLK),
    .i_rst_n            (i_rst_n),
    .i_emu_clk18mncen_n (i_emu_clk18mncen_n),
    .i_clk9mpcen_n      (o_clk9mpcen_n),
    .i_clk9mncen_n      (o_clk9mncen_n),
    .i_clk6mpcen_n      (o_clk6mpcen_n),
    .i_clk6mncen_n      (o_clk6mncen_n),
    .i_time1            (1'b0),
    .i_time2_n          (1'b1)
);

bind scroll_ram_port video_assert u_ram_assert
(
    .i_EMU_MCLK         (i_EMU_MCLK),
    .i_rst_n            (i_rst_n),
    .i_emu_clk18mncen_n (1'b1),
    .i_clk9mpcen_n      (1'b1),
    .i_clk9mncen_n      (1'b1),
    .i_clk6mpcen_n      (1'b1),
    .i_clk6mncen_n      (1'b1),
    .i_time1            (i_time1),
    .i_time2_n          (i_time2_n)
);

`default_nettype wire

/* source/video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_top
#(
    parameter video_pkg::hcount_t H_FIRST     = 9'd128,
    parameter video_pkg::hcount_t H_LAST      = 9'd511,
    parameter video_pkg::vcount_t V_FIRST     = 9'd248,
    parameter video_pkg::vcount_t V_LAST      = 9'd511,
    parameter video_pkg::hcount_t H_ACT_FIRST = 9'd160,
    parameter video_pkg::hcount_t H_ACT_LAST  = 9'd415,
    parameter video_pkg::vcount_t V_ACT_FIRST = 9'd272,
    parameter video_pkg::vcount_t V_ACT_LAST  = 9'd495,
    parameter video_pkg::vcount_t VSYNC_FIRST = 9'd248,
    parameter video_pkg::vcount_t VSYNC_LAST  = 9'd255
)
(
    input  wire                       i_EMU_MCLK,
    input  wire                       i_rst_n,
    input  wire                       i_emu_clk18mncen_n,

    input  wire video_pkg::cpu_addr_t i_cpu_addr,
    input  wire video_pkg::cpu_word_t i_cpu_dout,
    input  wire                       i_cpu_rw,
    input  wire                       i_cpu_lds_n,
    input  wire                       i_vzcs_n,

    output wire                       o_clk9mpcen_n,
    output wire                       o_clk9mncen_n,
    output wire                       o_clk6mpcen_n,
    output wire                       o_clk6mncen_n,

    output wire video_pkg::hcount_t   o_hcount,
    output wire video_pkg::vcount_t   o_vcount,
    output wire                       o_hblank_n,
    output wire                       o_vblank_n,
    output wire                       o_vsync_n,
    output wire                       o_blk,

    output wire                       o_time2_n,
    output wire                       o_champx,   // For CPU-side timing
    output wire video_pkg::cpu_word_t o_cpu_din,
    output wire video_pkg::byte_t     o_scroll_val
);

    wire clk6m;
    wire time1;

    //////////////////////////////
    // Clock enables
    //////////////////////////////

    cen_divider u_cen_divider
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_rst_n            (i_rst_n),
        .i_emu_clk18mncen_n (i_emu_clk18mncen_n),
        .o_clk9mpcen_n      (o_clk9mpcen_n),
        .o_clk9mncen_n      (o_clk9mncen_n),
        .o_clk6mpcen_n      (o_clk6mpcen_n),
        .o_clk6mncen_n      (o_clk6mncen_n),
        .o_clk6m            (clk6m)
    );

    //////////////////////////////
    // Raster and slot timing
    //////////////////////////////

    raster_timer
    #(
        .H_FIRST     (H_FIRST),
        .H_LAST      (H_LAST),
        .V_FIRST     (V_FIRST),
        .V_LAST      (V_LAST),
        .H_ACT_FIRST (H_ACT_FIRST),
        .H_ACT_LAST  (H_ACT_LAST),
        .V_ACT_FIRST (V_ACT_FIRST),
        .V_ACT_LAST  (V_ACT_LAST),
        .VSYNC_FIRST (VSYNC_FIRST),
        .VSYNC_LAST  (VSYNC_LAST)
    )
    u_raster_timer
    (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_rst_n       (i_rst_n),
        .i_clk6mpcen_n (o_clk6mpcen_n),
        .o_hcount      (o_hcount),
        .o_vcount      (o_vcount),
        .o_hblank_n    (o_hblank_n),
        .o_vblank_n    (o_vblank_n),
        .o_vsync_n     (o_vsync_n),
        .o_blk         (o_blk)
    );

    slot_timer u_slot_timer
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_rst_n            (i_rst_n),
        .i_emu_clk18mncen_n (i_emu_clk18mncen_n),
        .i_clk6mpcen_n      (o_clk6mpcen_n),
        .i_clk6m            (clk6m),
        .i_h1               (o_hcount[0]),
        .o_time1            (time1),
        .o_time2_n          (o_time2_n),
        .o_champx           (o_champx)
    );

    //////////////////////////////
    // Scroll RAM
    //////////////////////////////

    scroll_ram_port u_scroll_ram_port
    (
        .i_EMU_MCLK    (i_EMU_MCLK),
        .i_rst_n       (i_rst_n),
        .i_clk6mpcen_n (o_clk6mpcen_n),
        .i_hcount      (o_hcount),
        .i_vcount      (o_vcount),
        .i_hblank_n    (o_hblank_n),   // Stands in for VCLK
        .i_time1       (time1),
        .i_time2_n     (o_time2_n),
        .i_cpu_addr    (i_cpu_addr),
        .i_cpu_dout    (i_cpu_dout),
        .i_cpu_rw      (i_cpu_rw),
        .i_cpu_lds_n   (i_cpu_lds_n),
        .i_vzcs_n      (i_vzcs_n),
        .o_cpu_din     (o_cpu_din),
        .o_scroll_val  (o_scroll_val)
    );

endmodule

`default_nettype wire

/* source/scroll_ram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module scroll_ram_port
(
    input  wire                    i_EMU_MCLK,
    input  wire                    i_rst_n,
    input  wire                    i_clk6mpcen_n,

    input  wire video_pkg::hcount_t i_hcount,
    input  wire video_pkg::vcount_t i_vcount,
    input  wire                    i_hblank_n,   // Selects hscroll fetch when low

    input  wire                    i_time1,
    input  wire                    i_time2_n,

    input  wire video_pkg::cpu_addr_t i_cpu_addr,
    input  wire video_pkg::cpu_word_t i_cpu_dout, // CPU write data
    input  wire                    i_cpu_rw,     // High for read
    input  wire                    i_cpu_lds_n,
    input  wire                    i_vzcs_n,     // Scroll RAM select

    output video_pkg::cpu_word_t   o_cpu_din,
    output video_pkg::byte_t       o_scroll_val
);

    video_pkg::byte_t        scroll_ram [0:2047];
    video_pkg::byte_t        ram_q;       // Registered RAM output
    video_pkg::byte_t        cpu_latch;
    video_pkg::scroll_addr_t gfx_addr;
    video_pkg::scroll_addr_t ram_addr;
    logic                    ram_we;

    //////////////////////////////
    // Address mux
    //////////////////////////////

    // Graphics fetch address, flip not supported
    always_comb
    begin
        if (!i_hblank_n)
            gfx_addr = {1'b0, i_hcount[2:1], i_vcount[7:0]};     // Hscroll per line
        else
            gfx_addr = {4'b1111, i_hcount[2], i_hcount[8:3]};    // Vscroll per column
    end

    // Odd pixels belong to graphics, even pixels to the CPU
    assign ram_addr = i_hcount[0] ? gfx_addr : i_cpu_addr[10:0];

    // All strobes low together, only inside TIME2
    assign ram_we = ~(i_vzcs_n | i_cpu_rw | i_cpu_lds_n | i_time2_n);

    //////////////////////////////
    // 2K x 8 RAM
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (ram_we)
            scroll_ram[ram_addr] <= i_cpu_dout[7:0];  // Low byte only
        ram_q <= scroll_ram[ram_addr];
    end

    //////////////////////////////
    // Read latches
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
            cpu_latch <= '0;
        else if (i_time1)
            cpu_latch <= ram_q;   // Follows RAM while TIME1 is high
    end

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
            o_scroll_val <= '0;
        else if (!i_clk6mpcen_n && i_hcount[0])
            o_scroll_val <= ram_q; // End of graphics pixel
    end

    //////////////////////////////
    // CPU data mux
    //////////////////////////////

    always_comb
    begin
        if (!i_vzcs_n)
            o_cpu_din = {video_pkg::CPU_PULLUP, cpu_latch};
        else
            o_cpu_din = '1;        // Bus pulled up
    end

endmodule

`default_nettype wire

/* source/slot_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_timer
(
    input  wire  i_EMU_MCLK,
    input  wire  i_rst_n,
    input  wire  i_emu_clk18mncen_n,
    input  wire  i_clk6mpcen_n,
    input  wire  i_clk6m,      // 6M level, low at end of pixel
    input  wire  i_h1,         // hcount bit 0

    output logic o_time1,      // CPU read latch enable
    output logic o_time2_n,    // RAM write window
    output logic o_champx      // Row/column mux select
);

    logic       h1_dly;        // 1H one pixel late
    logic [3:1] slot_sr;       // QA..QC, QA loaded first

    //////////////////////////////
    // 1H delay flop
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
            h1_dly <= 1'b0;
        else if (!i_clk6mpcen_n)
            h1_dly <= i_h1;    // High through every even pixel
    end

    //////////////////////////////
    // 18M step shift register
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            slot_sr <= '0;
        end
        else if (!i_emu_clk18mncen_n)
        begin
            slot_sr[3]   <= h1_dly;       // Enters at the top
            slot_sr[2:1] <= slot_sr[3:2];
        end
    end

    // Strobes land in the last 18M period of the CPU pixel
    assign o_time1   = h1_dly & ~i_clk6m;
    assign o_time2_n = ~(h1_dly & slot_sr[2]);
    assign o_champx  = slot_sr[2] | slot_sr[1];

endmodule

`default_nettype wire

/* source/raster_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timer
#(
    parameter video_pkg::hcount_t H_FIRST     = 9'd128,
    parameter video_pkg::hcount_t H_LAST      = 9'd511,
    parameter video_pkg::vcount_t V_FIRST     = 9'd248,
    parameter video_pkg::vcount_t V_LAST      = 9'd511,
    parameter video_pkg::hcount_t H_ACT_FIRST = 9'd160,
    parameter video_pkg::hcount_t H_ACT_LAST  = 9'd415,
    parameter video_pkg::vcount_t V_ACT_FIRST = 9'd272,
    parameter video_pkg::vcount_t V_ACT_LAST  = 9'd495,
    parameter video_pkg::vcount_t VSYNC_FIRST = 9'd248,
    parameter video_pkg::vcount_t VSYNC_LAST  = 9'd255
)
(
    input  wire                i_EMU_MCLK,
    input  wire                i_rst_n,
    input  wire                i_clk6mpcen_n,  // Pixel clock enable

    output video_pkg::hcount_t o_hcount,
    output video_pkg::vcount_t o_vcount,
    output logic               o_hblank_n,
    output logic               o_vblank_n,
    output logic               o_vsync_n,
    output logic               o_blk         // High in the visible window
);

    // Levels at the reset position
    localparam logic RST_HACT  = (H_FIRST >= H_ACT_FIRST) && (H_FIRST <= H_ACT_LAST);
    localparam logic RST_VACT  = (V_FIRST >= V_ACT_FIRST) && (V_FIRST <= V_ACT_LAST);
    localparam logic RST_VSYNC = (V_FIRST >= VSYNC_FIRST) && (V_FIRST <= VSYNC_LAST);

    video_pkg::hcount_t hcount_next;
    video_pkg::vcount_t vcount_next;
    logic               line_end;
    logic               hact_next;
    logic               vact_next;
    logic               vsync_next;

    //////////////////////////////
    // Next count
    //////////////////////////////

    assign line_end = (o_hcount == H_LAST);

    always_comb
    begin
        hcount_next = line_end ? H_FIRST : o_hcount + 9'd1;

        if (!line_end)
            vcount_next = o_vcount;          // Hold mid-line
        else if (o_vcount == V_LAST)
            vcount_next = V_FIRST;           // Frame wrap
        else
            vcount_next = o_vcount + 9'd1;
    end

    // Decoded from the next count so levels move with the counters
    assign hact_next  = (hcount_next >= H_ACT_FIRST) && (hcount_next <= H_ACT_LAST);
    assign vact_next  = (vcount_next >= V_ACT_FIRST) && (vcount_next <= V_ACT_LAST);
    assign vsync_next = (vcount_next >= VSYNC_FIRST) && (vcount_next <= VSYNC_LAST);

    //////////////////////////////
    // Counters and levels
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            o_hcount   <= H_FIRST;
            o_vcount   <= V_FIRST;
            o_hblank_n <= RST_HACT;
            o_vblank_n <= RST_VACT;
            o_vsync_n  <= !RST_VSYNC;
            o_blk      <= RST_HACT && RST_VACT;
        end
        else if (!i_clk6mpcen_n)
        begin
            o_hcount   <= hcount_next;
            o_vcount   <= vcount_next;
            o_hblank_n <= hact_next;
            o_vblank_n <= vact_next;
            o_vsync_n  <= !vsync_next;   // Low in sync lines
            o_blk      <= hact_next && vact_next;
        end
    end

endmodule

`default_nettype wire

/* source/cen_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module cen_divider
(
    input  wire  i_EMU_MCLK,
    input  wire  i_rst_n,
    input  wire  i_emu_clk18mncen_n,  // Low every other MCLK

    output logic o_clk9mpcen_n,
    output logic o_clk9mncen_n,
    output logic o_clk6mpcen_n,
    output logic o_clk6mncen_n,
    output logic o_clk6m               // 6M level for the slot strobes
);

    video_pkg::cen_phase_e phase;
    logic [3:0]            cen_pattern;  // 9MP 9MN 6MP 6MN

    //////////////////////////////
    // Phase counter, mod 6
    //////////////////////////////

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!i_rst_n)
        begin
            phase       <= video_pkg::PH5;  // First 18M edge wraps to PH0
            cen_pattern <= 4'b1111;         // All enables idle
        end
        else if (!i_emu_clk18mncen_n)
        begin
            case (phase)
                video_pkg::PH0: phase <= video_pkg::PH1;
                video_pkg::PH1: phase <= video_pkg::PH2;
                video_pkg::PH2: phase <= video_pkg::PH3;
                video_pkg::PH3: phase <= video_pkg::PH4;
                video_pkg::PH4: phase <= video_pkg::PH5;
                default:        phase <= video_pkg::PH0;
            endcase

            // Pattern for the phase being left
            cen_pattern <= video_pkg::CEN_PATTERN[phase];
        end
    end

    // Qualified by 18M so each enable lasts one MCLK
    assign o_clk9mpcen_n = cen_pattern[video_pkg::CEN_9MP] | i_emu_clk18mncen_n;
    assign o_clk9mncen_n = cen_pattern[video_pkg::CEN_9MN] | i_emu_clk18mncen_n;
    assign o_clk6mpcen_n = cen_pattern[video_pkg::CEN_6MP] | i_emu_clk18mncen_n;
    assign o_clk6mncen_n = cen_pattern[video_pkg::CEN_6MN] | i_emu_clk18mncen_n;

    assign o_clk6m = cen_pattern[video_pkg::CEN_6MP];  // Low in last third of pixel

endmodule

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [8:0]  hcount_t;       // Pixel counter, 128..511
    typedef logic [8:0]  vcount_t;       // Line counter, 248..511
    typedef logic [10:0] scroll_addr_t;  // 2K scroll RAM
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_word_t;     // 68000 data bus
    typedef logic [14:0] cpu_addr_t;     // 68000 word address

    //////////////////////////////
    // Clock enable divider
    //////////////////////////////

    // Six 18M periods span two 6M periods and three 9M periods
    typedef enum logic [2:0] {
        PH0 = 3'd0,
        PH1 = 3'd1,
        PH2 = 3'd2,
        PH3 = 3'd3,
        PH4 = 3'd4,
        PH5 = 3'd5
    } cen_phase_e;

    // Bit positions inside a pattern
    localparam int CEN_9MP = 3;
    localparam int CEN_9MN = 2;
    localparam int CEN_6MP = 1;
    localparam int CEN_6MN = 0;

    // Active low, indexed by the phase held before the load
    localparam logic [3:0] CEN_PATTERN [0:5] = '{
        4'b0110, 4'b1001, 4'b0111, 4'b1010, 4'b0101, 4'b1011
    };

    // Unused upper byte on 8-bit devices
    localparam byte_t CPU_PULLUP = 8'hFF;

endpackage

`default_nettype wire
